/* design/prince_cfg.svh */
// Block, key, randomness and round-count macros for the masked PRINCE core
`ifndef PRINCE_CFG_SVH
`define PRINCE_CFG_SVH

// Data widths
`define PRINCE_BLOCK_W 64
`define PRINCE_KEY_W 128

// One masked S-box per nibble
`define PRINCE_NIBBLES 16

// Fresh randomness, one word per S-box
`define PRINCE_RAND_PER_SBOX 14
`define PRINCE_RAND_W 224

// Round counter range
// FWD runs from FIRST to MID, BWD ends at LAST
`define PRINCE_ROUND_FIRST 2
`define PRINCE_ROUND_MID 5
`define PRINCE_ROUND_LAST 11

`endif

/* design/prince_pkg.sv */
// Types, enums, linear-layer functions and round constants for masked PRINCE
`default_nettype none

`include "prince_cfg.svh"

package prince_pkg;

    typedef logic [`PRINCE_BLOCK_W-1:0] share_t;
    // Word 1 is k0, word 0 is k1
    typedef logic [1:0][`PRINCE_BLOCK_W-1:0] key_t;
    typedef logic [`PRINCE_RAND_W-1:0] rand_t;
    typedef logic [3:0] round_t;

    typedef enum logic {
        MODE_ENC,
        MODE_DEC
    } mode_e;

    typedef enum logic [2:0] {
        IDLE,
        LOAD,
        FWD,
        MID,
        BWD,
        FINISH
    } ctrl_state_e;

    ////////////////////////////////////////
    // Nibble permutations
    ////////////////////////////////////////

    // Nibble j, counted from the top, takes nibble 5j mod 16
    function automatic share_t shift_rows(input share_t x);
        share_t y;
        int src;
        for (int j = 0; j < 16; j++)
        begin
            src = (5 * j) % 16;
            y[(15 - j) * 4 +: 4] = x[(15 - src) * 4 +: 4];
        end
        return y;
    endfunction

    // 13 is the inverse of 5 mod 16
    function automatic share_t shift_rows_inv(input share_t x);
        share_t y;
        int src;
        for (int j = 0; j < 16; j++)
        begin
            src = (13 * j) % 16;
            y[(15 - j) * 4 +: 4] = x[(15 - src) * 4 +: 4];
        end
        return y;
    endfunction

    ////////////////////////////////////////
    // M' layer
    ////////////////////////////////////////

    // Each output bit is the XOR of the same bit in three of the four nibbles
    // of its 16-bit chunk. Outer chunks use M0, inner chunks M1.
    function automatic share_t m_prime(input share_t x);
        share_t y;
        int rot;
        int excl;
        y = '0;
        for (int ch = 0; ch < 4; ch++)
        begin
            rot = (ch == 0 || ch == 3) ? 3 : 4;
            for (int n = 0; n < 4; n++)
            begin
                for (int b = 0; b < 4; b++)
                begin
                    excl = (b + rot - n) % 4;
                    for (int k = 0; k < 4; k++)
                    begin
                        if (k != excl)
                            y[16 * ch + 4 * n + b] ^= x[16 * ch + 4 * k + b];
                    end
                end
            end
        end
        return y;
    endfunction

    ////////////////////////////////////////
    // Affine maps around the S-box
    ////////////////////////////////////////

    function automatic share_t affine_share1(input share_t x);
        share_t y;
        for (int i = 0; i < 16; i++)
        begin
            y[4 * i]     = x[4 * i + 1];
            y[4 * i + 1] = x[4 * i] ^ x[4 * i + 1] ^ x[4 * i + 2];
            y[4 * i + 2] = x[4 * i + 3];
            y[4 * i + 3] = x[4 * i + 2];
        end
        return y;
    endfunction

    // Constant part lives on share 0 only
    function automatic share_t affine_share0(input share_t x);
        return affine_share1(x) ^ {16{4'h5}};
    endfunction

    // Constant RC_i for encryption, RC_(11-i) for decryption
    function automatic share_t round_const(input round_t round, input mode_e mode);
        round_t idx;
        idx = (mode == MODE_DEC) ? 4'd11 - round : round;
        case (idx)
            4'd1:    return 64'h13198A2E03707344;
            4'd2:    return 64'hA4093822299F31D0;
            4'd3:    return 64'h082EFA98EC4E6C89;
            4'd4:    return 64'h452821E638D01377;
            4'd5:    return 64'hBE5466CF34E90C6C;
            4'd6:    return 64'h7EF84F78FD955CB1;
            4'd7:    return 64'h85840851F1AC43AA;
            4'd8:    return 64'hC882D32F25323C54;
            4'd9:    return 64'h64A51195E0E3610D;
            4'd10:   return 64'hD3B5A399CA0C2399;
            4'd11:   return 64'hC0AC29B7C97C50DD;
            default: return 64'h0000000000000000;
        endcase
    endfunction

endpackage

`default_nettype wire

/* design/prince_ctrl.sv */
// Round sequencer FSM for the masked PRINCE core
`timescale 1ns/1ps
`default_nettype none

`include "prince_cfg.svh"

module prince_ctrl (
    input  logic               clk,
    input  logic               reset,
    input  logic               go,
    output prince_pkg::round_t round,
    output logic               load,
    output logic               inv_pre,
    output logic               inv_post,
    output logic               finish
);
    import prince_pkg::*;

    // LOAD, FWD, two MID cycles and BWD before FINISH
    localparam int GO_TO_FINISH = `PRINCE_ROUND_LAST - `PRINCE_ROUND_FIRST + 5;

    ctrl_state_e state;
    logic        mid_second;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state      <= IDLE;
            round      <= round_t'(`PRINCE_ROUND_FIRST);
            mid_second <= 1'b0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    round <= round_t'(`PRINCE_ROUND_FIRST);
                    if (go)
                        state <= LOAD;
                end
                LOAD:
                    state <= FWD;
                FWD:
                begin
                    round <= round + 4'd1;
                    if (round == `PRINCE_ROUND_MID)
                        state <= MID;
                end
                // Two cycles for forward S and the switch to S inverse
                MID:
                begin
                    mid_second <= ~mid_second;
                    if (mid_second)
                        state <= BWD;
                end
                BWD:
                begin
                    if (round == `PRINCE_ROUND_LAST)
                        state <= FINISH;
                    else
                        round <= round + 4'd1;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

    assign load     = (state == LOAD);
    assign inv_pre  = (state == BWD) || (state == MID && mid_second);
    assign inv_post = (state == BWD);
    assign finish   = (state == FINISH);

    a_finish_pulse: assert property (@(posedge clk) disable iff (reset)
        (state == IDLE && go) |-> ##GO_TO_FINISH finish ##1 !finish);

    a_round_range: assert property (@(posedge clk) disable iff (reset)
        (state != IDLE) |-> (round >= `PRINCE_ROUND_FIRST && round <= `PRINCE_ROUND_LAST));

endmodule

`default_nettype wire

/* design/prince_sbox_masked.sv */
// Two-share masked PRINCE S-box with one register stage
`timescale 1ns/1ps
`default_nettype none

`include "prince_cfg.svh"

module prince_sbox_masked (
    input  logic                             clk,
    input  logic [`PRINCE_RAND_PER_SBOX-1:0] rand_in,
    input  logic [3:0]                       in0,
    input  logic [3:0]                       in1,
    output logic [3:0]                       out0,
    output logic [3:0]                       out1
);
    logic [`PRINCE_RAND_PER_SBOX-1:0] r;
    logic a0, b0, c0, d0, a1, b1, c1, d1;
    logic bal_ab, bal_ac, bal_ad, bal_bc, bal_bd, bal_cd;
    logic bal_abc, bal_abd, bal_acd, bal_bcd;
    logic [3:0] corr, corr_q, x0_q, x1_q;
    logic ab1_q, ac1_q, ad1_q, bc1_q, bd1_q, cd1_q;
    logic abc1_q, abd1_q, acd1_q, bcd1_q;
    logic qa0, qb0, qc0, qd0, qa1, qb1, qc1, qd1;
    logic ab, ac, ad, bc, bd, cd, abc, abd, acd, bcd;

    assign r = rand_in;
    assign {a0, b0, c0, d0} = in0;
    assign {a1, b1, c1, d1} = in1;

    ////////////////////////////////////////
    // Share 0 balancing terms
    ////////////////////////////////////////
    assign bal_ab = (a0 & b0) ^ (a0 & r[1]) ^ (b0 & r[0]) ^ r[4];
    assign bal_ac = (a0 & c0) ^ (a0 & r[2]) ^ (c0 & r[0]) ^ r[5];
    assign bal_ad = (a0 & d0) ^ (a0 & r[3]) ^ (d0 & r[0]) ^ r[6];
    assign bal_bc = (b0 & c0) ^ (b0 & r[2]) ^ (c0 & r[1]) ^ r[7];
    assign bal_bd = (b0 & d0) ^ (b0 & r[3]) ^ (d0 & r[1]) ^ r[8];
    assign bal_cd = (c0 & d0) ^ (c0 & r[3]) ^ (d0 & r[2]) ^ r[9];

    assign bal_abc = (a0 & b0 & c0) ^ (a0 & b0 & r[2]) ^ (a0 & c0 & r[1]) ^ (b0 & c0 & r[0])
        ^ (a0 & r[7]) ^ (b0 & r[5]) ^ (c0 & r[4]) ^ r[10];
    assign bal_abd = (a0 & b0 & d0) ^ (a0 & b0 & r[3]) ^ (a0 & d0 & r[1]) ^ (b0 & d0 & r[0])
        ^ (a0 & r[8]) ^ (b0 & r[6]) ^ (d0 & r[4]) ^ r[11];
    assign bal_acd = (a0 & c0 & d0) ^ (a0 & c0 & r[3]) ^ (a0 & d0 & r[2]) ^ (c0 & d0 & r[0])
        ^ (a0 & r[9]) ^ (c0 & r[6]) ^ (d0 & r[5]) ^ r[12];
    assign bal_bcd = (b0 & c0 & d0) ^ (b0 & c0 & r[3]) ^ (b0 & d0 & r[2]) ^ (c0 & d0 & r[1])
        ^ (b0 & r[9]) ^ (c0 & r[8]) ^ (d0 & r[7]) ^ r[13];

    assign corr[0] = r[0] ^ r[1] ^ bal_ab ^ bal_ad ^ bal_bc ^ bal_cd ^ bal_bcd;
    assign corr[1] = bal_ac ^ bal_bc ^ bal_bd ^ bal_abc ^ bal_bcd;
    assign corr[2] = r[0] ^ r[3] ^ bal_ac ^ bal_ad ^ bal_cd ^ bal_abc ^ bal_acd;
    assign corr[3] = r[0] ^ r[2] ^ bal_ab ^ bal_bc ^ bal_abd ^ bal_acd ^ bal_bcd;

    // Share 1 terms are re-masked before the register
    always_ff @(posedge clk)
    begin
        x0_q   <= in0;
        corr_q <= corr;
        x1_q   <= in1 ^ {r[0], r[1], r[2], r[3]};
        ab1_q  <= (a1 & b1) ^ r[4];
        ac1_q  <= (a1 & c1) ^ r[5];
        ad1_q  <= (a1 & d1) ^ r[6];
        bc1_q  <= (b1 & c1) ^ r[7];
        bd1_q  <= (b1 & d1) ^ r[8];
        cd1_q  <= (c1 & d1) ^ r[9];
        abc1_q <= (a1 & b1 & c1) ^ r[10];
        abd1_q <= (a1 & b1 & d1) ^ r[11];
        acd1_q <= (a1 & c1 & d1) ^ r[12];
        bcd1_q <= (b1 & c1 & d1) ^ r[13];
    end

    ////////////////////////////////////////
    // Cross terms after the register
    ////////////////////////////////////////
    assign {qa0, qb0, qc0, qd0} = x0_q;
    assign {qa1, qb1, qc1, qd1} = x1_q;

    assign ab = (qa0 & qb1) ^ (qa1 & qb0);
    assign ac = (qa0 & qc1) ^ (qa1 & qc0);
    assign ad = (qa0 & qd1) ^ (qa1 & qd0);
    assign bc = (qb0 & qc1) ^ (qb1 & qc0);
    assign bd = (qb0 & qd1) ^ (qb1 & qd0);
    assign cd = (qc0 & qd1) ^ (qc1 & qd0);

    assign abc = (qa0 & qb0 & qc1) ^ (qa0 & qc0 & qb1) ^ (qb0 & qc0 & qa1)
        ^ (qa0 & bc1_q) ^ (qb0 & ac1_q) ^ (qc0 & ab1_q);
    assign abd = (qa0 & qb0 & qd1) ^ (qa0 & qd0 & qb1) ^ (qb0 & qd0 & qa1)
        ^ (qa0 & bd1_q) ^ (qb0 & ad1_q) ^ (qd0 & ab1_q);
    assign acd = (qa0 & qc0 & qd1) ^ (qa0 & qd0 & qc1) ^ (qc0 & qd0 & qa1)
        ^ (qa0 & cd1_q) ^ (qc0 & ad1_q) ^ (qd0 & ac1_q);
    assign bcd = (qb0 & qc0 & qd1) ^ (qb0 & qd0 & qc1) ^ (qc0 & qd0 & qb1)
        ^ (qb0 & cd1_q) ^ (qc0 & bd1_q) ^ (qd0 & bc1_q);

    assign out0[0] = qa0 ^ qb0 ^ ab ^ ad ^ bc ^ cd ^ bcd ^ corr_q[0];
    assign out0[1] = ac ^ bc ^ bd ^ abc ^ bcd ^ corr_q[1];
    assign out0[2] = qa0 ^ qd0 ^ ac ^ ad ^ cd ^ abc ^ acd ^ corr_q[2];
    assign out0[3] = qa0 ^ qc0 ^ ab ^ bc ^ abd ^ acd ^ bcd ^ corr_q[3];

    assign out1[0] = 1'b1 ^ qa1 ^ qb1 ^ ab1_q ^ ad1_q ^ bc1_q ^ cd1_q ^ bcd1_q;
    assign out1[1] = 1'b1 ^ ac1_q ^ bc1_q ^ bd1_q ^ abc1_q ^ bcd1_q;
    assign out1[2] = qa1 ^ qd1 ^ ac1_q ^ ad1_q ^ cd1_q ^ abc1_q ^ acd1_q;
    assign out1[3] = 1'b1 ^ qa1 ^ qc1 ^ ab1_q ^ bc1_q ^ abd1_q ^ acd1_q ^ bcd1_q;

endmodule

`default_nettype wire

/* design/prince_round.sv */
// Masked PRINCE round datapath with key schedule, linear layers and S-box layer
`timescale 1ns/1ps
`default_nettype none

`include "prince_cfg.svh"

module prince_round (
    input  logic                clk,
    input  prince_pkg::mode_e   mode,
    input  logic                load,
    input  logic                inv_pre,
    input  logic                inv_post,
    input  prince_pkg::round_t  round,
    input  prince_pkg::share_t  share_in0,
    input  prince_pkg::share_t  share_in1,
    input  prince_pkg::key_t    key,
    input  prince_pkg::rand_t   rand_in,
    output prince_pkg::share_t  state0,
    output prince_pkg::share_t  state1,
    output prince_pkg::share_t  whiten_key
);
    import prince_pkg::*;

    share_t k0, k0_prime, k1, round_key;
    share_t loop0, loop1, sb_in0, sb_in1, sb_out0, sb_out1;
    share_t post0, post1, lin0, lin1;
    round_t rc_idx;

    assign k0       = key[1];
    assign k1       = key[0];
    assign k0_prime = {k0[0], k0[63:2], k0[1] ^ k0[63]};

    // k0 whitens the input on encryption, k0' on decryption
    assign whiten_key = (load ^ (mode == MODE_DEC)) ? k0 : k0_prime;

    // Forward constants go in before the S-box, backward ones after it
    always_comb
    begin
        if (load)
            rc_idx = '0;
        else if (inv_post)
            rc_idx = round;
        else
            rc_idx = round - 4'd1;
    end

    assign round_key = k1 ^ round_const(rc_idx, mode);

    ////////////////////////////////////////
    // Into the S-box layer
    ////////////////////////////////////////
    assign loop0 = load ? shift_rows_inv(share_in0 ^ whiten_key) : lin0;
    assign loop1 = load ? shift_rows_inv(share_in1) : lin1;

    // S inverse is the S-box wrapped in the affine maps
    assign sb_in0 = inv_pre ? affine_share0(loop0) : shift_rows(loop0) ^ round_key;
    assign sb_in1 = inv_pre ? affine_share1(loop1) : shift_rows(loop1);

    for (genvar i = 0; i < `PRINCE_NIBBLES; i++)
    begin : g_sbox
        prince_sbox_masked u_sbox (
            .clk     (clk),
            .rand_in (rand_in[i * `PRINCE_RAND_PER_SBOX +: `PRINCE_RAND_PER_SBOX]),
            .in0     (sb_in0[i * 4 +: 4]),
            .in1     (sb_in1[i * 4 +: 4]),
            .out0    (sb_out0[i * 4 +: 4]),
            .out1    (sb_out1[i * 4 +: 4])
        );
    end

    ////////////////////////////////////////
    // Out of the S-box layer
    ////////////////////////////////////////
    assign post0 = affine_share0(sb_out0) ^ round_key;
    assign post1 = affine_share1(sb_out1);

    assign lin0 = m_prime(inv_post ? shift_rows_inv(post0) : sb_out0);
    assign lin1 = m_prime(inv_post ? shift_rows_inv(post1) : sb_out1);

    // Holds the last backward round for the output stage
    always_ff @(posedge clk)
    begin
        state0 <= post0;
        state1 <= post1;
    end

endmodule

`default_nettype wire

/* design/prince_out_stage.sv */
// Output whitening, result share registers and done pulse
`timescale 1ns/1ps
`default_nettype none

module prince_out_stage (
    input  logic               clk,
    input  logic               reset,
    input  logic               finish,
    input  prince_pkg::share_t state0,
    input  prince_pkg::share_t state1,
    input  prince_pkg::share_t whiten_key,
    output prince_pkg::share_t share_out0,
    output prince_pkg::share_t share_out1,
    output logic               done
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            share_out0 <= '0;
            share_out1 <= '0;
            done       <= 1'b0;
        end
        else
        begin
            done <= finish;
            // Whitening key goes on share 0 only
            if (finish)
            begin
                share_out0 <= state0 ^ whiten_key;
                share_out1 <= state1;
            end
        end
    end

    a_hold_result: assert property (@(posedge clk) disable iff (reset)
        !finish |=> ($stable(share_out0) && $stable(share_out1)));

endmodule

`default_nettype wire

/* design/prince_top.sv */
// Top level of the masked PRINCE core
`timescale 1ns/1ps
`default_nettype none

module prince_top (
    input  logic               clk,
    input  logic               reset,
    input  logic               go,
    input  prince_pkg::mode_e  mode,
    input  prince_pkg::share_t share_in0,
    input  prince_pkg::share_t share_in1,
    input  prince_pkg::key_t   key,
    input  prince_pkg::rand_t  rand_in,
    output prince_pkg::share_t share_out0,
    output prince_pkg::share_t share_out1,
    output logic               done
);
    import prince_pkg::*;

    round_t round;
    logic   load, inv_pre, inv_post, finish;
    share_t state0, state1, whiten_key;

    prince_ctrl u_ctrl (
        .clk      (clk),
        .reset    (reset),
        .go       (go),
        .round    (round),
        .load     (load),
        .inv_pre  (inv_pre),
        .inv_post (inv_post),
        .finish   (finish)
    );

    prince_round u_round (
        .clk        (clk),
        .mode       (mode),
        .load       (load),
        .inv_pre    (inv_pre),
        .inv_post   (inv_post),
        .round      (round),
        .share_in0  (share_in0),
        .share_in1  (share_in1),
        .key        (key),
        .rand_in    (rand_in),
        .state0     (state0),
        .state1     (state1),
        .whiten_key (whiten_key)
    );

    prince_out_stage u_out (
        .clk        (clk),
        .reset      (reset),
        .finish     (finish),
        .state0     (state0),
        .state1     (state1),
        .whiten_key (whiten_key),
        .share_out0 (share_out0),
        .share_out1 (share_out1),
        .done       (done)
    );

endmodule

`default_nettype wire

/* test/tb_prince_model.svh */
// Unmasked PRINCE reference model with S-box tables and key derivation
`ifndef TB_PRINCE_MODEL_SVH
`define TB_PRINCE_MODEL_SVH

// S(x) and its inverse, entry 0 in the top nibble
localparam logic [63:0] SBOX_FWD = 64'hBF32AC916780E5D4;
localparam logic [63:0] SBOX_INV = 64'hB732FD89A6405EC1;

// Reflection constant, RC_i ^ RC_(11-i)
localparam logic [63:0] ALPHA = 64'hC0AC29B7C97C50DD;

function automatic share_t sbox_layer(input share_t x, input logic inv);
    share_t      y;
    logic [63:0] tbl;
    int          idx;
    tbl = inv ? SBOX_INV : SBOX_FWD;
    for (int i = 0; i < 16; i++)
    begin
        idx = x[4 * i +: 4];
        y[4 * i +: 4] = tbl[(15 - idx) * 4 +: 4];
    end
    return y;
endfunction

// k0' = (k0 >>> 1) ^ (k0 >> 63)
function automatic share_t derive_k0_prime(input share_t k0);
    return {k0[0], k0[63:1]} ^ (k0 >> 63);
endfunction

// Twelve S layers with the middle reflection
function automatic share_t prince_core(input share_t x, input share_t k1);
    share_t s;
    s = x ^ k1 ^ round_const(round_t'(0), MODE_ENC);
    for (int i = 1; i <= 5; i++)
    begin
        s = shift_rows(m_prime(sbox_layer(s, 1'b0)));
        s = s ^ k1 ^ round_const(round_t'(i), MODE_ENC);
    end
    s = sbox_layer(m_prime(sbox_layer(s, 1'b0)), 1'b1);
    for (int i = 6; i <= 10; i++)
    begin
        s = s ^ k1 ^ round_const(round_t'(i), MODE_ENC);
        s = sbox_layer(m_prime(shift_rows_inv(s)), 1'b1);
    end
    return s ^ k1 ^ round_const(round_t'(11), MODE_ENC);
endfunction

function automatic share_t prince_encrypt(input share_t pt, input key_t k);
    return derive_k0_prime(k[1]) ^ prince_core(pt ^ k[1], k[0]);
endfunction

// Decryption is encryption with the whitening keys swapped and k1 ^ alpha
function automatic share_t prince_decrypt(input share_t ct, input key_t k);
    return k[1] ^ prince_core(ct ^ derive_k0_prime(k[1]), k[0] ^ ALPHA);
endfunction

`endif

/* test/tb_prince.sv */
// Testbench for the masked PRINCE core with random stimulus and reference model
`timescale 1ns/1ps
`default_nettype none

`include "prince_cfg.svh"

module tb_prince;
    import prince_pkg::*;

    `include "tb_prince_model.svh"

    localparam int LATENCY    = 14;
    localparam int TIMEOUT    = 40;
    localparam int NUM_RANDOM = 200;
    localparam int NUM_DEC    = 50;
    localparam logic [63:0] KNOWN_CT = 64'h818665aa0d02dfda;

    logic   clk;
    logic   reset;
    logic   go;
    mode_e  mode;
    share_t share_in0, share_in1, share_out0, share_out1;
    key_t   key;
    rand_t  rand_in;
    logic   done;

    integer seed;
    int     errors;
    int     checks;
    share_t prev_out0, prev_out1;

    prince_top UUT (
        .clk        (clk),
        .reset      (reset),
        .go         (go),
        .mode       (mode),
        .share_in0  (share_in0),
        .share_in1  (share_in1),
        .key        (key),
        .rand_in    (rand_in),
        .share_out0 (share_out0),
        .share_out1 (share_out1),
        .done       (done)
    );

    initial
    begin
        clk = 1'b0;
    end

    always #20 clk = ~clk;

    ////////////////////////////////////////
    // Stimulus helpers
    ////////////////////////////////////////

    function automatic share_t draw_share();
        return {$random(seed), $random(seed)};
    endfunction

    function automatic rand_t draw_rand();
        rand_t r;
        for (int i = 0; i < `PRINCE_RAND_W / 32; i++)
            r[i * 32 +: 32] = $random(seed);
        return r;
    endfunction

    // Fresh masking randomness every cycle
    task automatic step_cycle();
        @(posedge clk);
        #1;
        rand_in = draw_rand();
    endtask

    task automatic check_share(input string name, input share_t exp, input share_t act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp)
        begin
            errors++;
            $display("[FAIL] %s: expected %b, actual %b", name, exp, act);
        end
    endtask

    // One block through the core, result is the XOR of the output shares
    task automatic run_block(input string name, input mode_e run_mode, input share_t data,
                             input key_t k, input logic busy_go, output share_t result);
        share_t mask;
        int     cycles;
        logic   seen;
        mask      = draw_share();
        mode      = run_mode;
        share_in0 = mask;
        share_in1 = data ^ mask;
        key       = k;
        go        = 1'b1;
        step_cycle();
        go     = 1'b0;
        cycles = 0;
        seen   = 1'b0;
        result = '0;
        while (!seen && cycles < TIMEOUT)
        begin
            step_cycle();
            cycles++;
            // Extra go in the middle of the run must be ignored
            go = busy_go && (cycles == 5);
            check_bit({name, " done timing"}, cycles == LATENCY, done);
            if (done)
                seen = 1'b1;
            else
            begin
                check_share({name, " hold out0"}, prev_out0, share_out0);
                check_share({name, " hold out1"}, prev_out1, share_out1);
            end
        end
        if (!seen)
        begin
            errors++;
            $display("Timeout: done did not rise within %0d cycles in %s", TIMEOUT, name);
        end
        else
        begin
            result    = share_out0 ^ share_out1;
            prev_out0 = share_out0;
            prev_out1 = share_out1;
            step_cycle();
            check_bit({name, " done pulse width"}, 1'b0, done);
        end
    endtask

    ////////////////////////////////////////
    // Test sequence
    ////////////////////////////////////////

    initial
    begin
        share_t pt, ct, back;
        key_t   k;
        seed      = 41;
        errors    = 0;
        checks    = 0;
        reset     = 1'b1;
        go        = 1'b0;
        mode      = MODE_ENC;
        share_in0 = '0;
        share_in1 = '0;
        key       = '0;
        rand_in   = '0;

        repeat (16) step_cycle();
        reset = 1'b0;

        // Idle core after reset
        for (int i = 0; i < 4; i++)
        begin
            step_cycle();
            check_bit("done before go", 1'b0, done);
        end
        check_share("reset out0", '0, share_out0);
        check_share("reset out1", '0, share_out1);
        prev_out0 = share_out0;
        prev_out1 = share_out1;

        check_share("model known vector", KNOWN_CT, prince_encrypt('0, '0));
        run_block("known vector", MODE_ENC, '0, '0, 1'b0, ct);
        check_share("known vector", KNOWN_CT, ct);

        for (int n = 0; n < NUM_RANDOM; n++)
        begin
            pt = draw_share();
            k  = {draw_share(), draw_share()};
            run_block("random encrypt", MODE_ENC, pt, k, (n % 4) == 3, ct);
            check_share("random encrypt", prince_encrypt(pt, k), ct);
            run_block("decrypt back", MODE_DEC, ct, k, (n % 4) == 1, back);
            check_share("decrypt back", pt, back);
        end

        for (int n = 0; n < NUM_DEC; n++)
        begin
            ct = draw_share();
            k  = {draw_share(), draw_share()};
            run_block("random decrypt", MODE_DEC, ct, k, (n % 2) == 1, pt);
            check_share("random decrypt", prince_decrypt(ct, k), pt);
        end

        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
+incdir+design
+incdir+test
design/prince_pkg.sv
design/prince_ctrl.sv
design/prince_sbox_masked.sv
design/prince_round.sv
design/prince_out_stage.sv
design/prince_top.sv
test/tb_prince.sv

/* Bender.yml */
package:
  name: prince_masked

sources:
  - include_dirs:
      - design
    files:
      - design/prince_pkg.sv
      - design/prince_ctrl.sv
      - design/prince_sbox_masked.sv
      - design/prince_round.sv
      - design/prince_out_stage.sv
      - design/prince_top.sv
  - target: test
    include_dirs:
      - design
      - test
    files:
      - test/tb_prince.sv
